//--- project.f
+incdir+rtl
rtl/flash_pkg.sv
rtl/rom_pkg.sv
rtl/spi_flash_reader.sv
rtl/rom_loader.sv
rtl/rom_bank.sv
rtl/rom_wb_port.sv
rtl/boot_rom.sv
verif/spi_flash_model.sv
verif/rom_checker.sv
verif/tb_boot_rom.sv

//--- Bender.yml
package:
  name: boot_rom

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/flash_pkg.sv
      - rtl/rom_pkg.sv
      - rtl/spi_flash_reader.sv
      - rtl/rom_loader.sv
      - rtl/rom_bank.sv
      - rtl/rom_wb_port.sv
      - rtl/boot_rom.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/spi_flash_model.sv
      - verif/rom_checker.sv
      - verif/tb_boot_rom.sv

//--- verif/tb_boot_rom.sv
`timescale 1ns/1ps
`default_nettype none

`include "boot_rom_config.svh"

module tb_boot_rom;

  localparam int IMAGE_BYTES = 2 * `ROM_WORDS;
  localparam int LOAD_LIMIT  = 200000;   // a full load takes about 131k cycles.
  localparam int CYCLE_LIMIT = 16;

  logic                clk = 1'b0;
  logic                rst_n;
  logic                wb_cyc;
  logic                wb_stb;
  logic                wb_we;
  rom_pkg::rom_waddr_t wb_adr;
  rom_pkg::rom_word_t  wb_dat_w;
  wire rom_pkg::rom_word_t wb_dat_r;
  wire                 wb_ack;
  wire                 wb_err;
  wire                 spi_cs;
  wire                 spi_sclk;
  wire                 spi_mosi;
  wire                 spi_miso;
  wire                 image_done;
  int                  check_errors;
  int                  flash_faults;
  int                  timeout_cnt = 0;
  logic                abort = 1'b0;
  logic [2:0]          test_id = 3'd0;
  integer              seed = 32'h022b88e0;
  logic [7:0]          ref_image [IMAGE_BYTES];

  always #4 clk = ~clk;

  boot_rom i_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .wb_err   (wb_err),
    .spi_cs   (spi_cs),
    .spi_sclk (spi_sclk),
    .spi_mosi (spi_mosi),
    .spi_miso (spi_miso)
  );

  spi_flash_model i_flash (
    .rst_n      (rst_n),
    .spi_cs     (spi_cs),
    .spi_sclk   (spi_sclk),
    .spi_mosi   (spi_mosi),
    .spi_miso   (spi_miso),
    .image_done (image_done),
    .fault_cnt  (flash_faults)
  );

  rom_checker i_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .image_done (image_done),
    .test_id    (test_id),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .wb_err     (wb_err),
    .error_cnt  (check_errors)
  );

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
  endtask

  function automatic rom_pkg::rom_waddr_t random_addr();
    return rom_pkg::rom_waddr_t'($random(seed));
  endfunction

  // request stays on the bus until the ack or err cycle is over.
  task automatic bus_cycle(input logic we, input rom_pkg::rom_waddr_t adr, input int limit);
    int waited;
    if (abort) return;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = 16'($random(seed));
    waited   = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!(wb_ack || wb_err) && waited < limit);
    if (!(wb_ack || wb_err)) begin
      $display("Timeout: no answer to the %s at address 0x%03h within %0d cycles",
               we ? "write" : "read", adr, limit);
      timeout_cnt++;
      abort = 1'b1;
    end else begin
      @(negedge clk);   // answer is sampled at the next rising edge.
    end
  endtask

  task automatic bus_idle(input int n);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  task automatic random_traffic(input int n);
    int i;
    for (i = 0; i < n && !abort; i++) begin
      bus_cycle(($random(seed) & 7) == 0, random_addr(), CYCLE_LIMIT);   // about one write in 8.
      bus_idle($random(seed) & 3);
    end
  endtask

  initial begin
    int                  i;
    int                  j;
    int                  hold;
    rom_pkg::rom_waddr_t addr;
    rst_n    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    for (i = 0; i < IMAGE_BYTES; i++) begin
      ref_image[i] = 8'($random(seed));
      i_flash.image[i] = ref_image[i];
      i_checker.image[i] = ref_image[i];
    end
    apply_reset();

    // first read sits in wait states for the whole load.
    test_id = 3'd0;
    bus_cycle(1'b0, random_addr(), LOAD_LIMIT);
    bus_idle(2);

    test_id = 3'd1;
    random_traffic(400);

    test_id = 3'd2;
    for (i = 0; i < 24 && !abort; i++) begin
      addr = random_addr();
      bus_cycle(1'b1, addr, CYCLE_LIMIT);
      bus_idle($random(seed) & 1);
      bus_cycle(1'b0, addr, CYCLE_LIMIT);
      bus_idle(1);
    end

    test_id = 3'd3;
    for (i = 0; i < 10 && !abort; i++) begin
      for (j = 0; j < 8; j++) begin
        bus_cycle(1'b0, random_addr(), CYCLE_LIMIT);
      end
      bus_idle(3);
    end

    test_id = 3'd4;
    if (!abort) begin
      apply_reset();
      hold = 1000 + (($random(seed) & 32'h7fff_ffff) % 60000);   // well inside the stream.
      repeat (hold) @(negedge clk);
      apply_reset();
      bus_cycle(1'b0, random_addr(), LOAD_LIMIT);
      bus_idle(1);
      random_traffic(200);
    end

    bus_idle(4);
    i_flash.check_frames();
    $display("Error counts: checker %0d, flash model %0d, timeouts %0d",
             check_errors, flash_faults, timeout_cnt);
    if (check_errors == 0 && flash_faults == 0 && timeout_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/rom_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "boot_rom_config.svh"

module rom_checker (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      image_done,
  input  wire [2:0]                test_id,
  input  wire                      wb_cyc,
  input  wire                      wb_stb,
  input  wire                      wb_we,
  input  wire rom_pkg::rom_waddr_t wb_adr,
  input  wire rom_pkg::rom_word_t  wb_dat_r,
  input  wire                      wb_ack,
  input  wire                      wb_err,
  output int                       error_cnt
);

  logic [7:0]         image [2 * `ROM_WORDS];   // filled by the testbench top.
  logic               answered;
  rom_pkg::rom_word_t expected;

  initial begin
    error_cnt = 0;
    answered  = 1'b0;
  end

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd0:    return "load_gating";
      3'd1:    return "image_contents";
      3'd2:    return "write_reject";
      3'd3:    return "back_to_back";
      3'd4:    return "reset_during_load";
      default: return "unknown";
    endcase
  endfunction

  task automatic report_error(input string msg);
    error_cnt++;
    $display("Error in %s: %s (time %0t)", test_name(test_id), msg, $time);
  endtask

  // the master holds its request until the answer, so the request is still on the bus.
  always @(posedge clk) begin
    if (rst_n !== 1'b1) begin
      answered = 1'b0;
    end else begin
      if (wb_ack || wb_err) begin
        if (!(wb_cyc && wb_stb)) report_error("answer without a pending bus cycle");
        if (!image_done) report_error("answer before the flash image was fully read");
        if (answered) report_error("answer lasted more than one cycle");
        if (wb_ack && wb_err) begin
          report_error("ack and err high together");
        end else if (wb_we && wb_ack) begin
          report_error("write cycle was acknowledged instead of refused");
        end else if (!wb_we && wb_err) begin
          report_error("read cycle was answered with err");
        end else if (wb_ack) begin
          // big-endian, the byte at the even offset is the high byte.
          expected = {image[2 * int'(wb_adr)], image[2 * int'(wb_adr) + 1]};
          if (wb_dat_r !== expected) begin
            error_cnt++;
            $display("Mismatch in %s at address 0x%03h: expected 0x%04h, actual 0x%04h",
                     test_name(test_id), wb_adr, expected, wb_dat_r);
          end
        end
      end
      answered = wb_ack || wb_err;
    end
  end

endmodule

`default_nettype wire

//--- verif/spi_flash_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "boot_rom_config.svh"

module spi_flash_model (
  input  wire  rst_n,
  input  wire  spi_cs,
  input  wire  spi_sclk,
  input  wire  spi_mosi,
  output logic spi_miso,
  output logic image_done,
  output int   fault_cnt
);

  localparam int IMAGE_BYTES = 2 * `ROM_WORDS;
  localparam int FRAME_BITS  = 32 + 8 * IMAGE_BYTES;   // command plus whole image.

  logic [7:0]  image [IMAGE_BYTES];   // filled by the testbench top.
  logic [31:0] cmd;
  int          bit_cnt;
  int          frames;

  initial begin
    spi_miso   = 1'b0;
    image_done = 1'b0;
    fault_cnt  = 0;
    cmd        = '0;
    bit_cnt    = 0;
    frames     = 0;
  end

  task automatic report_fault(input string msg);
    fault_cnt++;
    $display("%s (time %0t)", msg, $time);
  endtask

  // a reset of the DUT aborts the open frame and starts a new load.
  always @(negedge rst_n) begin
    bit_cnt    = 0;
    frames     = 0;
    image_done = 1'b0;
  end

  always @(negedge spi_cs) begin
    if (rst_n === 1'b1) begin
      frames++;
      bit_cnt    = 0;
      image_done = 1'b0;
      if (frames > 1) begin
        report_fault("Error: chip select went low more than once during one load");
      end
    end
  end

  always @(posedge spi_sclk) begin
    if (rst_n === 1'b1 && spi_cs === 1'b0) begin
      if (bit_cnt < 32) begin
        cmd = {cmd[30:0], spi_mosi};
        if (bit_cnt == 31 && cmd !== {8'h03, `FLASH_BASE}) begin
          report_fault($sformatf("Mismatch in spi_framing: command expected 0x%08h, actual 0x%08h",
                                 {8'h03, `FLASH_BASE}, cmd));
        end
      end
      bit_cnt++;
    end
  end

  // data bits go out on the falling edge, MSB of each byte first.
  always @(negedge spi_sclk) begin
    int d;
    if (rst_n === 1'b1 && spi_cs === 1'b0 && bit_cnt >= 32) begin
      d = bit_cnt - 32;
      if (d < 8 * IMAGE_BYTES) begin
        spi_miso = image[d / 8][7 - (d % 8)];
      end else begin
        spi_miso = 1'b0;   // past the image.
      end
    end
  end

  always @(posedge spi_cs) begin
    if (rst_n === 1'b1) begin
      if (bit_cnt != FRAME_BITS) begin
        report_fault($sformatf("Mismatch in spi_framing: bits per frame expected %0d, actual %0d",
                               FRAME_BITS, bit_cnt));
      end else begin
        image_done = 1'b1;
      end
    end
  end

  task automatic check_frames();
    if (frames != 1) begin
      report_fault($sformatf("Mismatch in spi_framing: frames per load expected 1, actual %0d",
                             frames));
    end
  endtask

endmodule

`default_nettype wire

//--- rtl/boot_rom.sv
`timescale 1ns/1ps
`default_nettype none

`include "boot_rom_config.svh"

module boot_rom (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      wb_cyc,
  input  wire                      wb_stb,
  input  wire                      wb_we,
  input  wire rom_pkg::rom_waddr_t wb_adr,
  input  wire rom_pkg::rom_word_t  wb_dat_w,
  output wire rom_pkg::rom_word_t  wb_dat_r,
  output wire                      wb_ack,
  output wire                      wb_err,
  output wire                      spi_cs,
  output wire                      spi_sclk,
  output wire                      spi_mosi,
  input  wire                      spi_miso
);

  wire                                      fetch_en;
  wire flash_pkg::flash_addr_t              fetch_addr;
  wire                                      word_valid;
  wire rom_pkg::rom_word_t                  word_data;
  wire [`ROM_BANKS-1:0]                     bank_we;
  wire rom_pkg::bank_row_t                  bank_wrow;
  wire rom_pkg::rom_word_t                  bank_wdata;
  wire rom_pkg::bank_row_t                  bank_rrow;
  wire rom_pkg::rom_word_t [`ROM_BANKS-1:0] bank_rdata;
  wire                                      ready;

  spi_flash_reader i_reader (
    .clk        (clk),
    .rst_n      (rst_n),
    .fetch_en   (fetch_en),
    .fetch_addr (fetch_addr),
    .word_valid (word_valid),
    .word_data  (word_data),
    .spi_cs     (spi_cs),
    .spi_sclk   (spi_sclk),
    .spi_mosi   (spi_mosi),
    .spi_miso   (spi_miso)
  );

  rom_loader i_loader (
    .clk        (clk),
    .rst_n      (rst_n),
    .word_valid (word_valid),
    .word_data  (word_data),
    .fetch_en   (fetch_en),
    .fetch_addr (fetch_addr),
    .bank_we    (bank_we),
    .bank_wrow  (bank_wrow),
    .bank_wdata (bank_wdata),
    .ready      (ready)
  );

  // word-interleaved banks.
  for (genvar g = 0; g < `ROM_BANKS; g++) begin : g_bank
    rom_bank i_bank (
      .clk   (clk),
      .we    (bank_we[g]),
      .wrow  (bank_wrow),
      .rrow  (bank_rrow),
      .wdata (bank_wdata),
      .rdata (bank_rdata[g])
    );
  end

  rom_wb_port i_wb_port (
    .clk        (clk),
    .rst_n      (rst_n),
    .ready      (ready),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .bank_rrow  (bank_rrow),
    .bank_rdata (bank_rdata),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .wb_err     (wb_err)
  );

endmodule

`default_nettype wire

//--- rtl/rom_wb_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "boot_rom_config.svh"

module rom_wb_port (
  input  wire                                      clk,
  input  wire                                      rst_n,
  input  wire                                      ready,
  input  wire                                      wb_cyc,
  input  wire                                      wb_stb,
  input  wire                                      wb_we,
  input  wire rom_pkg::rom_waddr_t                 wb_adr,
  input  wire rom_pkg::rom_word_t                  wb_dat_w,
  output rom_pkg::bank_row_t                       bank_rrow,
  input  wire rom_pkg::rom_word_t [`ROM_BANKS-1:0] bank_rdata,
  output rom_pkg::rom_word_t                       wb_dat_r,
  output logic                                     wb_ack,
  output logic                                     wb_err
);

  logic               accept;
  logic               busy;   // one cycle between accept and answer.
  logic               we_q;
  rom_pkg::bank_sel_t bank_q;

  // stb is ignored until the answer is over.
  assign accept    = wb_cyc && wb_stb && ready && !busy && !wb_ack && !wb_err;
  assign bank_rrow = wb_adr[`ROM_ADDR_BITS-1:`ROM_BANK_BITS];
  assign wb_dat_r  = bank_rdata[bank_q];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy   <= 1'b0;
      we_q   <= 1'b0;
      wb_ack <= 1'b0;
      wb_err <= 1'b0;
    end else begin
      busy   <= accept;
      wb_ack <= busy && !we_q && wb_cyc;
      wb_err <= busy && we_q && wb_cyc;   // writes are refused.
      if (accept) begin
        we_q <= wb_we;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      bank_q <= wb_adr[`ROM_BANK_BITS-1:0];
    end
  end

  a_ack_err_excl: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(wb_ack && wb_err)
  ) else $error("wb_ack and wb_err high together.");

  // relies on the master holding cyc until the answer.
  a_answer_in_cycle: assert property (
    @(posedge clk) disable iff (!rst_n)
    (wb_ack || wb_err) |-> wb_cyc
  ) else $error("wishbone answer outside of a bus cycle.");

endmodule

`default_nettype wire

//--- rtl/rom_bank.sv
`timescale 1ns/1ps
`default_nettype none

module rom_bank (
  input  wire                     clk,
  input  wire                     we,
  input  wire rom_pkg::bank_row_t wrow,
  input  wire rom_pkg::bank_row_t rrow,
  input  wire rom_pkg::rom_word_t wdata,
  output rom_pkg::rom_word_t      rdata
);

  // one row per bank-interleaved image word.
  localparam int unsigned DEPTH = 1 << $bits(rom_pkg::bank_row_t);

  rom_pkg::rom_word_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wrow] <= wdata;
    end
  end

  always_ff @(posedge clk) begin
    rdata <= mem[rrow];   // registered read.
  end

endmodule

`default_nettype wire

//--- rtl/rom_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "boot_rom_config.svh"

module rom_loader (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        word_valid,
  input  wire rom_pkg::rom_word_t    word_data,
  output logic                       fetch_en,
  output flash_pkg::flash_addr_t     fetch_addr,
  output logic [`ROM_BANKS-1:0]      bank_we,
  output rom_pkg::bank_row_t         bank_wrow,
  output rom_pkg::rom_word_t         bank_wdata,
  output logic                       ready
);

  rom_pkg::rom_waddr_t word_cnt;
  rom_pkg::bank_sel_t  wbank;
  logic                last_word;

  // consecutive words land in consecutive banks.
  assign wbank      = word_cnt[`ROM_BANK_BITS-1:0];
  assign bank_wrow  = word_cnt[`ROM_ADDR_BITS-1:`ROM_BANK_BITS];
  assign bank_wdata = word_data;
  assign last_word  = (word_cnt == rom_pkg::rom_waddr_t'(`ROM_WORDS - 1));

  // two flash bytes per word.
  assign fetch_addr = flash_pkg::flash_addr_t'(`FLASH_BASE) +
                      flash_pkg::flash_addr_t'({word_cnt, 1'b0});

  always_comb begin
    bank_we = '0;
    if (word_valid) begin
      bank_we[wbank] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_cnt <= '0;
      fetch_en <= 1'b0;
      ready    <= 1'b0;
    end else if (!ready) begin
      fetch_en <= 1'b1;
      if (word_valid) begin
        word_cnt <= word_cnt + 1'b1;
        if (last_word) begin
          ready    <= 1'b1;
          fetch_en <= 1'b0;   // reader raises cs on the next cycle.
        end
      end
    end
  end

  // the reader must stop pulsing once the image is in.
  a_we_onehot: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(bank_we) && !(ready && (|bank_we))
  ) else $error("bank write enable not one-hot or active after load.");

endmodule

`default_nettype wire

//--- rtl/spi_flash_reader.sv
`timescale 1ns/1ps
`default_nettype none

module spi_flash_reader (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         fetch_en,
  input  wire flash_pkg::flash_addr_t fetch_addr,
  output logic                        word_valid,
  output rom_pkg::rom_word_t          word_data,
  output logic                        spi_cs,
  output logic                        spi_sclk,
  output logic                        spi_mosi,
  input  wire                         spi_miso
);

  flash_pkg::spi_state_t   state;
  flash_pkg::flash_frame_u cmd_frame;
  logic [31:0]             cmd_shift;
  logic [4:0]              bit_cnt;   // bits left in the current field.

  always_comb begin
    cmd_frame.fields.opcode = flash_pkg::FLASH_READ;
    cmd_frame.fields.addr   = fetch_addr;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= flash_pkg::IDLE;
      spi_cs     <= 1'b1;
      spi_sclk   <= 1'b1;
      spi_mosi   <= 1'b0;
      cmd_shift  <= '0;
      bit_cnt    <= '0;
      word_valid <= 1'b0;
      word_data  <= '0;
    end else begin
      word_valid <= 1'b0;
      case (state)
        flash_pkg::IDLE: begin
          if (fetch_en) begin
            // first sclk fall goes out together with cs.
            spi_cs    <= 1'b0;
            spi_sclk  <= 1'b0;
            spi_mosi  <= cmd_frame.word[31];
            cmd_shift <= {cmd_frame.word[30:0], 1'b0};
            bit_cnt   <= 5'd31;
            state     <= flash_pkg::COMMAND;
          end
        end

        flash_pkg::COMMAND,
        flash_pkg::STREAM: begin
          if (!fetch_en) begin
            spi_cs <= 1'b1;   // sclk is parked one cycle later.
            state  <= flash_pkg::DONE;
          end else if (spi_sclk) begin
            spi_sclk <= 1'b0;
            if (state == flash_pkg::COMMAND) begin
              spi_mosi  <= cmd_shift[31];
              cmd_shift <= {cmd_shift[30:0], 1'b0};
            end
          end else begin
            // rising edge, the flash has held miso since the fall.
            spi_sclk <= 1'b1;
            if (state == flash_pkg::STREAM) begin
              word_data <= {word_data[14:0], spi_miso};
            end
            if (bit_cnt == 5'd0) begin
              bit_cnt <= 5'd15;
              if (state == flash_pkg::COMMAND) begin
                state <= flash_pkg::STREAM;
              end else begin
                word_valid <= 1'b1;   // high byte came in first.
              end
            end else begin
              bit_cnt <= bit_cnt - 5'd1;
            end
          end
        end

        flash_pkg::DONE: begin
          spi_sclk <= 1'b1;
          state    <= flash_pkg::IDLE;
        end

        default: begin
          state <= flash_pkg::IDLE;
        end
      endcase
    end
  end

  a_cs_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state == flash_pkg::IDLE) |-> spi_cs
  ) else $error("spi_cs is low while the reader is idle.");

endmodule

`default_nettype wire

//--- rtl/rom_pkg.sv
`default_nettype none

`include "boot_rom_config.svh"

package rom_pkg;

  typedef logic [15:0] rom_word_t;

  // word address as seen on the bus.
  typedef logic [`ROM_ADDR_BITS-1:0] rom_waddr_t;

  // low address bits pick the bank.
  typedef logic [`ROM_BANK_BITS-1:0] bank_sel_t;

  // remaining high bits pick the row inside a bank.
  typedef logic [`ROM_ADDR_BITS-`ROM_BANK_BITS-1:0] bank_row_t;

endpackage

`default_nettype wire

//--- rtl/flash_pkg.sv
`default_nettype none

package flash_pkg;

  // only the plain read command is issued.
  typedef enum logic [7:0] {
    FLASH_READ = 8'h03
  } flash_opcode_t;

  typedef logic [23:0] flash_addr_t;

  // opcode goes out first, then the address MSB first.
  typedef struct packed {
    flash_opcode_t opcode;
    flash_addr_t   addr;
  } flash_frame_t;

  typedef union packed {
    flash_frame_t fields;
    logic [31:0]  word;   // shift view.
  } flash_frame_u;

  typedef enum logic [1:0] {
    IDLE,
    COMMAND,
    STREAM,
    DONE
  } spi_state_t;

endpackage

`default_nettype wire

//--- rtl/boot_rom_config.svh
`ifndef BOOT_ROM_CONFIG_SVH
`define BOOT_ROM_CONFIG_SVH

// word-address width of the boot image.
`define ROM_ADDR_BITS 12

// number of image words.
`define ROM_WORDS (1 << `ROM_ADDR_BITS)

// log2 of the bank count, banks take the low word-address bits.
`define ROM_BANK_BITS 2

`define ROM_BANKS (1 << `ROM_BANK_BITS)

// byte offset of the image inside the flash.
`define FLASH_BASE 24'h100000

`endif
